// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes, instruction bits [6:2]
    localparam logic [4:0] RV_OPC_LOAD   = 5'b00000;
    localparam logic [4:0] RV_OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] RV_OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] RV_OPC_STORE  = 5'b01000;
    localparam logic [4:0] RV_OPC_OP     = 5'b01100;
    localparam logic [4:0] RV_OPC_LUI    = 5'b01101;
    localparam logic [4:0] RV_OPC_BRANCH = 5'b11000;
    localparam logic [4:0] RV_OPC_JALR   = 5'b11001;
    localparam logic [4:0] RV_OPC_JAL    = 5'b11011;
    localparam logic [4:0] RV_OPC_SYSTEM = 5'b11100;

    // low two bits of any 32-bit encoding
    localparam logic [1:0] RV_LEN_FULL   = 2'b11;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [4:0] opcode;
        logic [1:0] len;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  len;
    } rv_i_fmt_t;

    // B format shares this layout
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [4:0] opcode;
        logic [1:0] len;
    } rv_s_fmt_t;

    // J format shares this layout
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  len;
    } rv_u_fmt_t;

    typedef union packed {
        logic [31:0] raw;
        rv_r_fmt_t   r;
        rv_i_fmt_t   i;
        rv_s_fmt_t   s;
        rv_u_fmt_t   u;
    } rv_instr_u;

endpackage

// File: source/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    typedef struct packed {
        logic add_override;
        logic op2_inverse;
        logic shift_arith;
        logic m_group;
        logic div_sel;
    } rv_alu_ctrl_t;

    // one-hot
    typedef struct packed {
        logic memory;
        logic pc_next;
        logic alu;
    } rv_res_src_t;

    typedef struct packed {
        logic [11:0] idx;
        logic [4:0]  imm;
        logic        imm_sel;
        logic        write;
        logic        set;
        logic        clear;
        logic        read;
        logic        ebreak;
        logic        mret;
    } rv_csr_ctrl_t;

    typedef struct packed {
        logic         reg_write;
        logic         op1_pc;
        logic         op2_imm;
        logic         jal;
        logic         jalr;
        logic         branch;
        logic         store;
        logic         csr_req;
        rv_alu_ctrl_t alu;
        rv_res_src_t  res_src;
    } rv_dec_ctrl_t;

endpackage

// File: source/rv_instr_latch.sv
`timescale 1ns/1ps

module rv_instr_latch import rv_isa_pkg::*;
#(
    parameter int PC_BITS = 16
)
(
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_stall,
    input  logic               i_flush,
    input  logic               i_ready,
    input  logic [31:0]        i_instr,
    input  logic [PC_BITS-1:1] i_pc,
    input  logic [PC_BITS-1:1] i_pc_next,
    output rv_instr_u          o_instr,
    output logic               o_valid,
    output logic [PC_BITS-1:1] o_pc,
    output logic [PC_BITS-1:1] o_pc_next
);

    logic [31:0] instr_in;

    // a word without ready becomes all zero, which decodes as nothing
    assign instr_in = i_ready ? i_instr : '0;

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_instr.raw <= '0;
            o_valid     <= 1'b0;
        end
        else if (i_flush)
        begin
            o_instr.raw <= '0;
            o_valid     <= 1'b0;
        end
        else if (!i_stall)
        begin
            o_instr.raw <= instr_in;
            o_valid     <= i_ready;
        end
    end

    // pc pair rides along with the word
    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_pc      <= '0;
            o_pc_next <= '0;
        end
        else if (!i_flush && !i_stall)
        begin
            o_pc      <= i_pc;
            o_pc_next <= i_pc_next;
        end
    end

endmodule

// File: source/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen import rv_isa_pkg::*;
(
    input  rv_instr_u   i_instr,
    output logic [31:0] o_imm
);

    logic [4:0]  op;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign op = i_instr.r.opcode;

    assign imm_i = {{21{i_instr.i.imm[11]}}, i_instr.i.imm[10:0]};
    assign imm_s = {{21{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi[5:0], i_instr.s.imm_lo};
    // branch offset scattered over the S fields
    assign imm_b = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_lo[0],
                    i_instr.s.imm_hi[5:0], i_instr.s.imm_lo[4:1], 1'b0};
    assign imm_u = {i_instr.u.imm, 12'b0};
    // jump offset scattered over the U field
    assign imm_j = {{12{i_instr.u.imm[19]}}, i_instr.u.imm[7:0], i_instr.u.imm[8],
                    i_instr.u.imm[18:9], 1'b0};

    // lui and auipc share the low bits 101
    assign o_imm = (op[2:0] == 3'b101)    ? imm_u :
                   (op == RV_OPC_JAL)     ? imm_j :
                   (op == RV_OPC_STORE)   ? imm_s :
                   (op == RV_OPC_BRANCH)  ? imm_b :
                                            imm_i;

endmodule

// File: source/rv_ctrl_decode.sv
`timescale 1ns/1ps

module rv_ctrl_decode import rv_isa_pkg::*, rv_ctrl_pkg::*;
#(
    parameter bit EXT_M     = 1'b1,
    parameter bit EXT_ZICSR = 1'b1
)
(
    input  rv_instr_u    i_instr,
    input  logic         i_valid,
    output logic [4:0]   o_rs1,
    output logic [4:0]   o_rs2,
    output logic [4:0]   o_rd,
    output logic [2:0]   o_funct3,
    output rv_dec_ctrl_t o_ctrl,
    output rv_csr_ctrl_t o_csr,
    output logic         o_inst_supported
);

    logic [4:0] op;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic       full;
    logic       is_load, is_op_imm, is_auipc, is_store, is_op;
    logic       is_lui, is_branch, is_jalr, is_jal, is_system;
    logic       op_base, op_mul, slt_sel;
    logic       add_override, inv_force, inv_clear;
    logic       trap, ecall, ebreak, mret, csr_req;

    assign op     = i_instr.r.opcode;
    assign funct3 = i_instr.r.funct3;
    assign funct7 = i_instr.r.funct7;
    assign rs2    = i_instr.r.rs2;
    assign full   = (i_instr.r.len == RV_LEN_FULL);

    // instruction groups
    assign is_load   = full & (op == RV_OPC_LOAD);
    assign is_op_imm = full & (op == RV_OPC_OP_IMM);
    assign is_auipc  = full & (op == RV_OPC_AUIPC);
    assign is_store  = full & (op == RV_OPC_STORE);
    assign is_op     = full & (op == RV_OPC_OP);
    assign is_lui    = full & (op == RV_OPC_LUI);
    assign is_branch = full & (op == RV_OPC_BRANCH);
    assign is_jalr   = full & (op == RV_OPC_JALR);
    assign is_jal    = full & (op == RV_OPC_JAL);
    assign is_system = full & (op == RV_OPC_SYSTEM);

    // funct7 bit 0 marks the mul/div group
    assign op_base = is_op & !funct7[0];
    assign op_mul  = is_op & funct7[0] & EXT_M;
    assign slt_sel = (funct3[2:1] == 2'b01);

    // system: traps with funct3 zero, csr access otherwise
    assign trap    = is_system & (funct3 == 3'b000);
    assign ecall   = trap & !funct7[3] & !rs2[0];
    assign ebreak  = trap & !funct7[3] & rs2[0];
    assign mret    = trap & funct7[4] & (rs2[2:1] == 2'b01);
    assign csr_req = is_system & (|funct3) & EXT_ZICSR;

    assign add_override = is_load | is_store | is_auipc | is_lui | is_jal | is_jalr;
    // compares subtract, plain adds never invert
    assign inv_force = is_branch | (is_op_imm & slt_sel) | (op_base & slt_sel);
    assign inv_clear = add_override | is_op_imm;

    assign o_rs1    = is_lui ? 5'd0 : i_instr.r.rs1;
    assign o_rs2    = rs2;
    assign o_rd     = i_instr.r.rd;
    assign o_funct3 = funct3;

    assign o_ctrl.reg_write = full & !is_store & !is_branch;
    assign o_ctrl.op1_pc    = is_auipc | is_jal;
    assign o_ctrl.op2_imm   = !(is_op | is_branch);
    assign o_ctrl.jal       = is_jal;
    assign o_ctrl.jalr      = is_jalr;
    assign o_ctrl.branch    = is_branch;
    assign o_ctrl.store     = is_store;
    assign o_ctrl.csr_req   = csr_req;

    assign o_ctrl.alu.add_override = add_override;
    assign o_ctrl.alu.op2_inverse  = inv_force ? 1'b1 :
                                     inv_clear ? 1'b0 :
                                                 funct7[5];
    assign o_ctrl.alu.shift_arith  = funct7[5];
    assign o_ctrl.alu.m_group      = op_mul;
    assign o_ctrl.alu.div_sel      = op_mul & funct3[2];

    assign o_ctrl.res_src.memory  = is_load;
    assign o_ctrl.res_src.pc_next = is_jal | is_jalr;
    assign o_ctrl.res_src.alu     = !(is_load | is_jal | is_jalr);

    assign o_csr.idx     = i_instr.i.imm;
    assign o_csr.imm     = i_instr.i.rs1;
    assign o_csr.imm_sel = funct3[2];
    assign o_csr.write   = csr_req & (funct3[1:0] == 2'b01);
    assign o_csr.set     = csr_req & (funct3[1:0] == 2'b10);
    assign o_csr.clear   = csr_req & (funct3[1:0] == 2'b11);
    assign o_csr.read    = csr_req;
    assign o_csr.ebreak  = ebreak;
    assign o_csr.mret    = mret;

    // an empty slot never raises an illegal instruction
    assign o_inst_supported = !i_valid |
                              is_load | is_op_imm | is_auipc | is_store | is_lui |
                              op_base | op_mul | is_branch | is_jal |
                              (is_jalr & (funct3 == 3'b000)) |
                              ecall | ebreak | csr_req | (mret & EXT_ZICSR);

endmodule

// File: source/rv_decode_top.sv
`timescale 1ns/1ps

module rv_decode_top import rv_isa_pkg::*, rv_ctrl_pkg::*;
#(
    parameter int PC_BITS   = 16,
    parameter bit EXT_M     = 1'b1,
    parameter bit EXT_ZICSR = 1'b1
)
(
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_stall,
    input  logic               i_flush,
    input  logic               i_ready,
    input  logic [31:0]        i_instr,
    input  logic [PC_BITS-1:1] i_pc,
    input  logic [PC_BITS-1:1] i_pc_next,
    output logic [PC_BITS-1:1] o_pc,
    output logic [PC_BITS-1:1] o_pc_next,
    output logic [4:0]         o_rs1,
    output logic [4:0]         o_rs2,
    output logic [4:0]         o_rd,
    output logic [31:0]        o_imm,
    output logic [2:0]         o_funct3,
    output rv_dec_ctrl_t       o_ctrl,
    output rv_csr_ctrl_t       o_csr,
    output logic               o_inst_supported
);

    rv_instr_u instr;
    logic      valid;

    rv_instr_latch #(
        .PC_BITS    (PC_BITS)
    ) u_latch (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_ready    (i_ready),
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .i_pc_next  (i_pc_next),
        .o_instr    (instr),
        .o_valid    (valid),
        .o_pc       (o_pc),
        .o_pc_next  (o_pc_next)
    );

    // both decoders work on the same latched word
    rv_imm_gen u_imm_gen (
        .i_instr    (instr),
        .o_imm      (o_imm)
    );

    rv_ctrl_decode #(
        .EXT_M      (EXT_M),
        .EXT_ZICSR  (EXT_ZICSR)
    ) u_ctrl_decode (
        .i_instr          (instr),
        .i_valid          (valid),
        .o_rs1            (o_rs1),
        .o_rs2            (o_rs2),
        .o_rd             (o_rd),
        .o_funct3         (o_funct3),
        .o_ctrl           (o_ctrl),
        .o_csr            (o_csr),
        .o_inst_supported (o_inst_supported)
    );

endmodule

// File: bench/tb_rv_decode_vectors.svh
typedef struct packed {
    logic [31:0] instr;
    logic        ready;
    logic [31:0] imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [15:0] ctrl;
    logic [11:0] csr_idx;
    logic [4:0]  csr_imm;
    logic [6:0]  csr_flags;
    logic        supported;
} vector_t;

localparam int NUM_VECTORS = 26;

// word, ready, imm, rs1, rs2, rd, funct3
// then ctrl, csr index, csr imm, csr flags, supported
// ctrl bits in groups of rw op1pc op2imm jal | jalr br st csr | add inv sra mul div | mem pcn alu
// csr flag bits imm_sel write set clear read ebreak mret
localparam vector_t VECTORS [NUM_VECTORS] = '{
    // addi x1, x2, -1 and addi x3, x4, 0x7ff
    '{32'hFFF10093, 1'b1, 32'hFFFFFFFF, 5'd2, 5'd31, 5'd1, 3'b000,
      16'b1010_0000_00100_001, 12'hFFF, 5'd2, 7'b0000000, 1'b1},
    '{32'h7FF20193, 1'b1, 32'h000007FF, 5'd4, 5'd31, 5'd3, 3'b000,
      16'b1010_0000_00100_001, 12'h7FF, 5'd4, 7'b0000000, 1'b1},
    // sw with offsets -4 and 8
    '{32'hFE532E23, 1'b1, 32'hFFFFFFFC, 5'd6, 5'd5, 5'd28, 3'b010,
      16'b0010_0010_10100_001, 12'hFE5, 5'd6, 7'b0000000, 1'b1},
    '{32'h00532423, 1'b1, 32'h00000008, 5'd6, 5'd5, 5'd8, 3'b010,
      16'b0010_0010_10000_001, 12'h005, 5'd6, 7'b0000000, 1'b1},
    // beq -8, bne +16
    '{32'hFE208CE3, 1'b1, 32'hFFFFFFF8, 5'd1, 5'd2, 5'd25, 3'b000,
      16'b0000_0100_01100_001, 12'hFE2, 5'd1, 7'b0000000, 1'b1},
    '{32'h00419863, 1'b1, 32'h00000010, 5'd3, 5'd4, 5'd16, 3'b001,
      16'b0000_0100_01000_001, 12'h004, 5'd3, 7'b0000000, 1'b1},
    // lui with nonzero bits in the rs1 field, then auipc
    '{32'h812AB3B7, 1'b1, 32'h812AB000, 5'd0, 5'd18, 5'd7, 3'b011,
      16'b1010_0000_10000_001, 12'h812, 5'd21, 7'b0000000, 1'b1},
    '{32'h12345417, 1'b1, 32'h12345000, 5'd8, 5'd3, 5'd8, 3'b101,
      16'b1110_0000_10000_001, 12'h123, 5'd8, 7'b1000000, 1'b1},
    // jal -4, jal +8, jalr 4(x5), lw 12(x11)
    '{32'hFFDFF0EF, 1'b1, 32'hFFFFFFFC, 5'd31, 5'd29, 5'd1, 3'b111,
      16'b1111_0000_10100_010, 12'hFFD, 5'd31, 7'b1000000, 1'b1},
    '{32'h0080006F, 1'b1, 32'h00000008, 5'd0, 5'd8, 5'd0, 3'b000,
      16'b1111_0000_10000_010, 12'h008, 5'd0, 7'b0000000, 1'b1},
    '{32'h004280E7, 1'b1, 32'h00000004, 5'd5, 5'd4, 5'd1, 3'b000,
      16'b1010_1000_10000_010, 12'h004, 5'd5, 7'b0000000, 1'b1},
    '{32'h00C5A503, 1'b1, 32'h0000000C, 5'd11, 5'd12, 5'd10, 3'b010,
      16'b1010_0000_10000_100, 12'h00C, 5'd11, 7'b0000000, 1'b1},
    // add, sub, slt, sra, sltiu
    '{32'h003100B3, 1'b1, 32'h00000003, 5'd2, 5'd3, 5'd1, 3'b000,
      16'b1000_0000_00000_001, 12'h003, 5'd2, 7'b0000000, 1'b1},
    '{32'h403100B3, 1'b1, 32'h00000403, 5'd2, 5'd3, 5'd1, 3'b000,
      16'b1000_0000_01100_001, 12'h403, 5'd2, 7'b0000000, 1'b1},
    '{32'h0062A233, 1'b1, 32'h00000006, 5'd5, 5'd6, 5'd4, 3'b010,
      16'b1000_0000_01000_001, 12'h006, 5'd5, 7'b0000000, 1'b1},
    '{32'h409453B3, 1'b1, 32'h00000409, 5'd8, 5'd9, 5'd7, 3'b101,
      16'b1000_0000_01100_001, 12'h409, 5'd8, 7'b1000000, 1'b1},
    '{32'hFFF13093, 1'b1, 32'hFFFFFFFF, 5'd2, 5'd31, 5'd1, 3'b011,
      16'b1010_0000_01100_001, 12'hFFF, 5'd2, 7'b0000000, 1'b1},
    // mul, div
    '{32'h023100B3, 1'b1, 32'h00000023, 5'd2, 5'd3, 5'd1, 3'b000,
      16'b1000_0000_00010_001, 12'h023, 5'd2, 7'b0000000, 1'b1},
    '{32'h023140B3, 1'b1, 32'h00000023, 5'd2, 5'd3, 5'd1, 3'b100,
      16'b1000_0000_00011_001, 12'h023, 5'd2, 7'b1000000, 1'b1},
    // csrrw, csrrs, csrrci, ebreak, mret
    '{32'h305110F3, 1'b1, 32'h00000305, 5'd2, 5'd5, 5'd1, 3'b001,
      16'b1010_0001_00000_001, 12'h305, 5'd2, 7'b0100100, 1'b1},
    '{32'h342021F3, 1'b1, 32'h00000342, 5'd0, 5'd2, 5'd3, 3'b010,
      16'b1010_0001_00000_001, 12'h342, 5'd0, 7'b0010100, 1'b1},
    '{32'h30047073, 1'b1, 32'h00000300, 5'd8, 5'd0, 5'd0, 3'b111,
      16'b1010_0001_00000_001, 12'h300, 5'd8, 7'b1001100, 1'b1},
    '{32'h00100073, 1'b1, 32'h00000001, 5'd0, 5'd1, 5'd0, 3'b000,
      16'b1010_0000_00000_001, 12'h001, 5'd0, 7'b0000010, 1'b1},
    '{32'h30200073, 1'b1, 32'h00000302, 5'd0, 5'd2, 5'd0, 3'b000,
      16'b1010_0000_00000_001, 12'h302, 5'd0, 7'b0000001, 1'b1},
    // flw is outside the decoded set
    '{32'h00012087, 1'b1, 32'h00000000, 5'd2, 5'd0, 5'd1, 3'b010,
      16'b1010_0000_00000_001, 12'h000, 5'd2, 7'b0000000, 1'b0},
    // add presented without ready
    '{32'h003100B3, 1'b0, 32'h00000000, 5'd0, 5'd0, 5'd0, 3'b000,
      16'b0010_0000_00000_001, 12'h000, 5'd0, 7'b0000000, 1'b1}
};

// File: bench/tb_rv_decode.sv
`timescale 1ns/1ps

module tb_rv_decode
    import rv_ctrl_pkg::*;
();

    localparam int PC_BITS   = 16;
    localparam int CLK_HALF  = 20;
    localparam int STALL_ROW = 19;

    `include "tb_rv_decode_vectors.svh"

    logic               clk = 1'b0;
    logic               i_rst_n;
    logic               i_stall;
    logic               i_flush;
    logic               i_ready;
    logic [31:0]        i_instr;
    logic [PC_BITS-1:1] i_pc;
    logic [PC_BITS-1:1] i_pc_next;
    logic [PC_BITS-1:1] o_pc;
    logic [PC_BITS-1:1] o_pc_next;
    logic [4:0]         o_rs1;
    logic [4:0]         o_rs2;
    logic [4:0]         o_rd;
    logic [31:0]        o_imm;
    logic [2:0]         o_funct3;
    rv_dec_ctrl_t       o_ctrl;
    rv_csr_ctrl_t       o_csr;
    logic               o_inst_supported;

    int                 cycle_count = 0;
    int                 checks = 0;
    int                 errors = 0;
    string              cur_tag = "reset";
    logic [31:0]        lcg_state;
    logic [PC_BITS-1:1] exp_pc;
    logic [PC_BITS-1:1] exp_pc_next;

    always #CLK_HALF clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    rv_decode_top #(
        .PC_BITS    (PC_BITS),
        .EXT_M      (1'b1),
        .EXT_ZICSR  (1'b1)
    ) UUT (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_stall          (i_stall),
        .i_flush          (i_flush),
        .i_ready          (i_ready),
        .i_instr          (i_instr),
        .i_pc             (i_pc),
        .i_pc_next        (i_pc_next),
        .o_pc             (o_pc),
        .o_pc_next        (o_pc_next),
        .o_rs1            (o_rs1),
        .o_rs2            (o_rs2),
        .o_rd             (o_rd),
        .o_imm            (o_imm),
        .o_funct3         (o_funct3),
        .o_ctrl           (o_ctrl),
        .o_csr            (o_csr),
        .o_inst_supported (o_inst_supported)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("Mismatch %s: got %h, expected %h (%s)", name, got, expected, cur_tag);
        end
    endtask

    // polls once per ns, so it returns 1 ns after the last counted edge
    task automatic wait_cycles(input int n);
        int target;
        int spins;
        target = cycle_count + n;
        spins = 0;
        while (cycle_count < target && spins < n * 2 * CLK_HALF + 10)
        begin
            #1;
            spins++;
        end
        if (cycle_count < target)
        begin
            errors++;
            $display("Timeout: clock did not advance %0d cycles (%s)", n, cur_tag);
        end
    endtask

    // new random pc pair from the upper lcg bits
    task automatic drive_word(input logic [31:0] word, input logic ready);
        i_instr = word;
        i_ready = ready;
        lcg_state = lcg_next(lcg_state);
        i_pc = lcg_state[PC_BITS+14:16];
        lcg_state = lcg_next(lcg_state);
        i_pc_next = lcg_state[PC_BITS+14:16];
    endtask

    task automatic check_row(input vector_t v);
        check_value("o_imm", o_imm, v.imm);
        check_value("o_rs1", 32'(o_rs1), 32'(v.rs1));
        check_value("o_rs2", 32'(o_rs2), 32'(v.rs2));
        check_value("o_rd", 32'(o_rd), 32'(v.rd));
        check_value("o_funct3", 32'(o_funct3), 32'(v.funct3));
        check_value("o_ctrl", 32'(o_ctrl), 32'(v.ctrl));
        check_value("o_csr", 32'(o_csr), 32'({v.csr_idx, v.csr_imm, v.csr_flags}));
        check_value("o_inst_supported", 32'(o_inst_supported), 32'(v.supported));
    endtask

    task automatic check_pcs();
        check_value("o_pc", 32'(o_pc), 32'(exp_pc));
        check_value("o_pc_next", 32'(o_pc_next), 32'(exp_pc_next));
    endtask

    task automatic check_empty_slot();
        check_value("o_ctrl.reg_write", 32'(o_ctrl.reg_write), 32'h0);
        check_value("o_csr write/set/clear", 32'({o_csr.write, o_csr.set, o_csr.clear}), 32'h0);
        check_value("o_inst_supported", 32'(o_inst_supported), 32'h1);
    endtask

    initial
    begin
        i_rst_n = 1'b0;
        i_stall = 1'b0;
        i_flush = 1'b0;
        i_ready = 1'b0;
        i_instr = '0;
        i_pc = '0;
        i_pc_next = '0;
        lcg_state = 32'h2802;
        wait_cycles(2);
        i_rst_n = 1'b1;
        check_empty_slot();
        exp_pc = '0;
        exp_pc_next = '0;
        check_pcs();

        for (int n = 0; n < NUM_VECTORS; n++)
        begin
            cur_tag = $sformatf("row %0d", n);
            drive_word(VECTORS[n].instr, VECTORS[n].ready);
            exp_pc = i_pc;
            exp_pc_next = i_pc_next;
            wait_cycles(1);
            check_row(VECTORS[n]);
            check_pcs();
        end

        cur_tag = "stall";
        drive_word(VECTORS[STALL_ROW].instr, 1'b1);
        exp_pc = i_pc;
        exp_pc_next = i_pc_next;
        wait_cycles(1);
        // a different word and pc pair must not get through
        i_stall = 1'b1;
        drive_word(VECTORS[2].instr, 1'b1);
        wait_cycles(1);
        check_row(VECTORS[STALL_ROW]);
        check_pcs();

        cur_tag = "flush";
        i_stall = 1'b0;
        i_flush = 1'b1;
        drive_word(VECTORS[STALL_ROW].instr, 1'b1);
        wait_cycles(1);
        check_empty_slot();
        i_flush = 1'b0;

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: tb.f
+incdir+bench
source/rv_isa_pkg.sv
source/rv_ctrl_pkg.sv
source/rv_instr_latch.sv
source/rv_imm_gen.sv
source/rv_ctrl_decode.sv
source/rv_decode_top.sv
bench/tb_rv_decode.sv

// File: run_sim.sh
#!/bin/sh
# builds the decode testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -f tb.f --top-module tb_rv_decode -o tb_rv_decode; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/tb_rv_decode > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation did not complete"
    exit 1
fi

cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
exit 0
